//--- design/board_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "vcf_settings.svh"

module board_loader
    import vcf_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_row_req,
    input  row_t       i_row,
    input  wire        i_lvl_done,
    input  level_rsp_t i_lvl_rsp,
    output logic       o_row_ack,
    output logic       o_busy,
    output logic       o_lvl_start,
    output level_req_t o_lvl_req,
    output logic       o_done,
    output logic       o_win,
    output move_t      o_move
);

    board_t    board_r;
    coord_t    row_cnt;
    cell_idx_t row_base;
    logic      row_take;
    logic      start_pend;

    assign row_base = cell_idx_t'(row_cnt * `VCF_N);
    assign row_take = !o_busy && i_row_req && !o_row_ack;

    always_ff @(posedge i_clk) begin
        if (row_take) begin
            board_r[row_base +: `VCF_N] <= i_row;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            row_cnt     <= '0;
            o_row_ack   <= 1'b0;
            o_busy      <= 1'b0;
            start_pend  <= 1'b0;
            o_lvl_start <= 1'b0;
            o_done      <= 1'b0;
            o_win       <= 1'b0;
            o_move      <= '0;
        end else begin
            start_pend  <= 1'b0;
            o_lvl_start <= start_pend;
            o_done      <= 1'b0;
            if (row_take) begin
                o_row_ack <= 1'b1;
            end else if (!o_busy && !i_row_req && o_row_ack) begin
                o_row_ack <= 1'b0;
                // last row in, launch level 0 a cycle after ack falls
                if (row_cnt == coord_t'(`VCF_N - 1)) begin
                    row_cnt    <= '0;
                    o_busy     <= 1'b1;
                    start_pend <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 4'd1;
                end
            end
            if (i_lvl_done) begin
                o_done <= 1'b1;
                o_win  <= i_lvl_rsp.win;
                o_move <= i_lvl_rsp.move;
            end
            // busy covers the done cycle
            if (o_done) begin
                o_busy <= 1'b0;
            end
        end
    end

    assign o_lvl_req.board = board_r;
    assign o_lvl_req.move  = '0;

endmodule

`default_nettype wire

//--- design/kill_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "vcf_settings.svh"

module kill_node
    import vcf_pkg::*;
#(
    parameter int LEVEL = 0
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_start,
    input  level_req_t i_req,
    input  wire        i_child_done,
    input  level_rsp_t i_child_rsp,
    output logic       o_done,
    output level_rsp_t o_rsp,
    output logic       o_child_start,
    output level_req_t o_child_req
);

    localparam bit    ATTACK = (LEVEL % 2) == 0;
    localparam cell_t SIDE   = ATTACK ? CELL_ATK : CELL_DEF;
    localparam int    CW     = $clog2(`VCF_MAX_CAND);

    node_state_t                    state;
    logic [3:0]                     cand_ptr;
    level_rsp_t                     rsp_r;
    logic                           child_start_r;
    level_req_t                     child_req_r;
    move_t                          cand;
    cell_idx_t                      cand_idx;
    board_t                         next_board;
    logic                           scan_done;
    logic [3:0]                     five_cnt;
    logic [3:0]                     four_cnt;
    move_t [`VCF_MAX_CAND-1:0]      five_list;
    move_t [`VCF_MAX_CAND-1:0]      four_list;

    // every level looks at the attacker's threats
    threat_scan u_scan (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_board    (i_req.board),
        .i_side     (CELL_ATK),
        .o_done     (scan_done),
        .o_five_cnt (five_cnt),
        .o_five     (five_list),
        .o_four_cnt (four_cnt),
        .o_four     (four_list)
    );

    // attacker walks the four list, defender blocks the single five
    assign cand     = ATTACK ? four_list[cand_ptr[CW-1:0]] : five_list[0];
    assign cand_idx = cell_idx_t'(cand.y * `VCF_N + cand.x);

    always_comb begin
        next_board           = i_req.board;
        next_board[cand_idx] = SIDE;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= IDLE;
            cand_ptr      <= '0;
            rsp_r         <= '0;
            child_start_r <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_start) state <= SCAN;
                end
                SCAN: begin
                    if (scan_done) begin
                        cand_ptr <= '0;
                        if (ATTACK) begin
                            if (five_cnt != 4'd0) begin
                                rsp_r <= '{win: 1'b1, move: five_list[0]};
                                state <= DONE;
                            end else if (four_cnt == 4'd0) begin
                                rsp_r <= '{win: 1'b0, move: '0};
                                state <= DONE;
                            end else begin
                                state <= TRY;
                            end
                        end else begin
                            if (five_cnt == 4'd0) begin
                                rsp_r <= '{win: 1'b0, move: '0};
                                state <= DONE;
                            end else if (five_cnt == 4'd1) begin
                                state <= TRY;
                            end else begin
                                // two open fives, no single block holds
                                rsp_r <= '{win: 1'b1, move: five_list[0]};
                                state <= DONE;
                            end
                        end
                    end
                end
                TRY: begin
                    child_start_r <= 1'b1;
                    state         <= WAIT;
                end
                WAIT: begin
                    child_start_r <= 1'b0;
                    if (i_child_done) begin
                        if (!ATTACK) begin
                            rsp_r <= '{win: i_child_rsp.win, move: child_req_r.move};
                            state <= DONE;
                        end else if (i_child_rsp.win) begin
                            rsp_r <= '{win: 1'b1, move: child_req_r.move};
                            state <= DONE;
                        end else if (cand_ptr + 4'd1 == four_cnt) begin
                            rsp_r <= '{win: 1'b0, move: '0};
                            state <= DONE;
                        end else begin
                            cand_ptr <= cand_ptr + 4'd1;
                            state    <= TRY;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // held until the child answers
    always_ff @(posedge i_clk) begin
        if (state == TRY) begin
            child_req_r.board <= next_board;
            child_req_r.move  <= cand;
        end
    end

    assign o_done        = state == DONE;
    assign o_rsp         = rsp_r;
    assign o_child_start = child_start_r;
    assign o_child_req   = child_req_r;

endmodule

`default_nettype wire

//--- design/leaf_evaluator.sv
`timescale 1ns/1ps
`default_nettype none

`include "vcf_settings.svh"

module leaf_evaluator
    import vcf_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_start,
    input  level_req_t i_req,
    output logic       o_done,
    output level_rsp_t o_rsp
);

    logic                      scan_done;
    logic [3:0]                five_cnt;
    move_t [`VCF_MAX_CAND-1:0] five_list;

    threat_scan u_scan (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_board    (i_req.board),
        .i_side     (CELL_ATK),
        .o_done     (scan_done),
        .o_five_cnt (five_cnt),
        .o_five     (five_list),
        .o_four_cnt (),
        .o_four     ()
    );

    // only an immediate five counts this deep
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_done <= 1'b0;
            o_rsp  <= '0;
        end else begin
            o_done <= scan_done;
            if (scan_done) begin
                o_rsp.win  <= five_cnt != 4'd0;
                o_rsp.move <= (five_cnt != 4'd0) ? five_list[0] : '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/threat_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "vcf_settings.svh"

module threat_scan
    import vcf_pkg::*;
(
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_start,
    input  board_t                       i_board,
    input  cell_t                        i_side,
    output logic                         o_done,
    output logic [3:0]                   o_five_cnt,
    output move_t [`VCF_MAX_CAND-1:0]    o_five,
    output logic [3:0]                   o_four_cnt,
    output move_t [`VCF_MAX_CAND-1:0]    o_four
);

    localparam int    CW        = $clog2(`VCF_MAX_CAND);
    // off-board marker, blocks like an opponent stone
    localparam cell_t CELL_EDGE = 2'd3;

    logic      run;
    coord_t    scan_x;
    coord_t    scan_y;
    cell_idx_t idx;
    logic [1:0] res;
    logic      hit_five;
    logic      hit_four;
    logic      s1_five;
    logic      s1_four;
    logic      s1_last;
    move_t     s1_move;

    // 9 cells centred on (y, x), with the side's stone placed in the middle
    function automatic cell_t [8:0] get_line(input board_t b, input int y, input int x,
                                              input int dy, input int dx, input cell_t side);
        cell_t [8:0] line;
        int r;
        int c;
        for (int k = 0; k < 9; k++) begin
            r = y + dy * (k - 4);
            c = x + dx * (k - 4);
            if (r >= 0 && r < `VCF_N && c >= 0 && c < `VCF_N) begin
                line[k] = b[r * `VCF_N + c];
            end else begin
                line[k] = CELL_EDGE;
            end
        end
        line[4] = side;
        return line;
    endfunction

    // bit 1 five or longer, bit 0 some window of five holds four plus one empty
    function automatic logic [1:0] eval_line(input cell_t [8:0] line, input cell_t side);
        int   run_len;
        int   n_side;
        int   n_empty;
        logic grow_lo;
        logic grow_hi;
        logic four;
        run_len = 1;
        grow_lo = 1'b1;
        grow_hi = 1'b1;
        four    = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            if (grow_hi && line[4 + k] == side) run_len++;
            else grow_hi = 1'b0;
            if (grow_lo && line[4 - k] == side) run_len++;
            else grow_lo = 1'b0;
        end
        for (int s = 0; s <= 4; s++) begin
            n_side  = 0;
            n_empty = 0;
            for (int k = 0; k < 5; k++) begin
                if (line[s + k] == side) n_side++;
                else if (line[s + k] == CELL_EMPTY) n_empty++;
            end
            if (n_side == 4 && n_empty == 1) four = 1'b1;
        end
        return {run_len >= 5, four};
    endfunction

    // horizontal, vertical and both diagonals
    assign res = eval_line(get_line(i_board, scan_y, scan_x, 0, 1, i_side), i_side)
               | eval_line(get_line(i_board, scan_y, scan_x, 1, 0, i_side), i_side)
               | eval_line(get_line(i_board, scan_y, scan_x, 1, 1, i_side), i_side)
               | eval_line(get_line(i_board, scan_y, scan_x, 1, -1, i_side), i_side);

    assign hit_five = run && i_board[idx] == CELL_EMPTY && res[1];
    assign hit_four = run && i_board[idx] == CELL_EMPTY && !res[1] && res[0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run        <= 1'b0;
            scan_x     <= '0;
            scan_y     <= '0;
            idx        <= '0;
            s1_five    <= 1'b0;
            s1_four    <= 1'b0;
            s1_last    <= 1'b0;
            o_five_cnt <= '0;
            o_four_cnt <= '0;
            o_done     <= 1'b0;
        end else begin
            s1_five <= hit_five;
            s1_four <= hit_four;
            s1_last <= run && idx == cell_idx_t'(`VCF_CELLS - 1);
            o_done  <= s1_last;
            if (i_start) begin
                run        <= 1'b1;
                scan_x     <= '0;
                scan_y     <= '0;
                idx        <= '0;
                o_five_cnt <= '0;
                o_four_cnt <= '0;
            end else begin
                if (run) begin
                    idx <= idx + 8'd1;
                    if (scan_x == coord_t'(`VCF_N - 1)) begin
                        scan_x <= '0;
                        scan_y <= scan_y + 4'd1;
                    end else begin
                        scan_x <= scan_x + 4'd1;
                    end
                    if (idx == cell_idx_t'(`VCF_CELLS - 1)) run <= 1'b0;
                end
                // counts saturate at capacity
                if (s1_five && o_five_cnt < `VCF_MAX_CAND) o_five_cnt <= o_five_cnt + 4'd1;
                if (s1_four && o_four_cnt < `VCF_MAX_CAND) o_four_cnt <= o_four_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        s1_move.x <= scan_x;
        s1_move.y <= scan_y;
        if (s1_five && o_five_cnt < `VCF_MAX_CAND) o_five[o_five_cnt[CW-1:0]] <= s1_move;
        if (s1_four && o_four_cnt < `VCF_MAX_CAND) o_four[o_four_cnt[CW-1:0]] <= s1_move;
    end

endmodule

`default_nettype wire

//--- design/vcf_pkg.sv
`default_nettype none

`include "vcf_settings.svh"

package vcf_pkg;

    typedef logic [1:0] cell_t;
    typedef logic [3:0] coord_t;
    typedef logic [7:0] cell_idx_t;

    localparam cell_t CELL_EMPTY = 2'd0;
    localparam cell_t CELL_ATK   = 2'd1;
    localparam cell_t CELL_DEF   = 2'd2;

    // raster order, element i is row i/15, column i%15
    typedef cell_t [`VCF_CELLS-1:0] board_t;
    typedef cell_t [`VCF_N-1:0]     row_t;

    // x is the column, y the row
    typedef struct packed {
        coord_t x;
        coord_t y;
    } move_t;

    typedef struct packed {
        board_t board;
        move_t  move;
    } level_req_t;

    typedef struct packed {
        logic  win;
        move_t move;
    } level_rsp_t;

    typedef enum logic [2:0] {IDLE, SCAN, TRY, WAIT, DONE} node_state_t;

endpackage

`default_nettype wire

//--- design/vcf_settings.svh
`ifndef VCF_SETTINGS_SVH
`define VCF_SETTINGS_SVH

// board side and cell count
`define VCF_N        15
`define VCF_CELLS    225

// kill-node levels, kept even so the leaf is an attacker level
`define VCF_DEPTH    4

// candidates kept per scan
`define VCF_MAX_CAND 8

`endif

//--- design/vcf_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vcf_settings.svh"

module vcf_top
    import vcf_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_rst_n,
    input  wire   i_row_req,
    input  row_t  i_row,
    output logic  o_row_ack,
    output logic  o_busy,
    output logic  o_done,
    output logic  o_win,
    output move_t o_move
);

    // link k runs from the parent of level k into level k, the last one into the leaf
    logic [`VCF_DEPTH:0] lvl_start;
    logic [`VCF_DEPTH:0] lvl_done;
    level_req_t          lvl_req [`VCF_DEPTH+1];
    level_rsp_t          lvl_rsp [`VCF_DEPTH+1];

    board_loader u_loader (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_row_req   (i_row_req),
        .i_row       (i_row),
        .i_lvl_done  (lvl_done[0]),
        .i_lvl_rsp   (lvl_rsp[0]),
        .o_row_ack   (o_row_ack),
        .o_busy      (o_busy),
        .o_lvl_start (lvl_start[0]),
        .o_lvl_req   (lvl_req[0]),
        .o_done      (o_done),
        .o_win       (o_win),
        .o_move      (o_move)
    );

    for (genvar k = 0; k < `VCF_DEPTH; k++) begin : g_level
        kill_node #(
            .LEVEL (k)
        ) u_node (
            .i_clk         (i_clk),
            .i_rst_n       (i_rst_n),
            .i_start       (lvl_start[k]),
            .i_req         (lvl_req[k]),
            .i_child_done  (lvl_done[k+1]),
            .i_child_rsp   (lvl_rsp[k+1]),
            .o_done        (lvl_done[k]),
            .o_rsp         (lvl_rsp[k]),
            .o_child_start (lvl_start[k+1]),
            .o_child_req   (lvl_req[k+1])
        );
    end

    leaf_evaluator u_leaf (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (lvl_start[`VCF_DEPTH]),
        .i_req   (lvl_req[`VCF_DEPTH]),
        .o_done  (lvl_done[`VCF_DEPTH]),
        .o_rsp   (lvl_rsp[`VCF_DEPTH])
    );

endmodule

`default_nettype wire

//--- gomoku_vcf.f
+incdir+design
design/vcf_pkg.sv
design/threat_scan.sv
design/kill_node.sv
design/leaf_evaluator.sv
design/board_loader.sv
design/vcf_top.sv
test/vcf_checker.sv
test/vcf_tb.sv

//--- test/vcf_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vcf_checker (
    input wire i_clk,
    input wire i_rst_n,
    input wire i_row_req,
    input wire i_row_ack,
    input wire i_busy,
    input wire i_done
);

    int fail_cnt = 0;

    // four-phase receiver side
    ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_row_ack) |-> $past(i_row_req))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("row ack rose without a pending request");
        end

    ack_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_row_ack) |-> !$past(i_row_req))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("row ack dropped while the request was still high");
        end

    done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |=> !i_done)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done held for more than one cycle");
        end

    done_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |-> i_busy)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done raised outside a search");
        end

    // control outputs quiet under reset
    reset_low: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_row_ack && !i_busy && !i_done)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("control outputs not low during reset");
        end

endmodule

bind vcf_top vcf_checker u_checker (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_row_req (i_row_req),
    .i_row_ack (o_row_ack),
    .i_busy    (o_busy),
    .i_done    (o_done)
);

`default_nettype wire

//--- test/vcf_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vcf_settings.svh"

module vcf_tb
    import vcf_pkg::*;
();

    localparam int NUM_PUZZLES = 6;
    localparam int SCAN_BUDGET = 20;
    localparam int SCAN_CYCLES = 230;
    localparam int LOAD_CYCLES = `VCF_N * 6;
    localparam int CYCLE_LIMIT = NUM_PUZZLES * (SCAN_BUDGET * SCAN_CYCLES + LOAD_CYCLES) + 40;

    logic   i_clk;
    logic   i_rst_n;
    logic   i_row_req;
    row_t   i_row;
    logic   o_row_ack;
    logic   o_busy;
    logic   o_done;
    logic   o_win;
    move_t  o_move;

    board_t puz;
    logic   exp_win;
    move_t  exp_move;
    int     errors;
    int     cycles;
    integer seed;

    vcf_top dut0 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_row_req (i_row_req),
        .i_row     (i_row),
        .o_row_ack (o_row_ack),
        .o_busy    (o_busy),
        .o_done    (o_done),
        .o_win     (o_win),
        .o_move    (o_move)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no verdict within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // verdict at each done
    win_check: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |-> o_win == exp_win)
        else begin
            errors = errors + 1;
            $display("MISMATCH o_win expected %h got %h", exp_win, $sampled(o_win));
        end

    move_check: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done && exp_win |-> o_move == exp_move)
        else begin
            errors = errors + 1;
            $display("MISMATCH o_move expected %h got %h", exp_move, $sampled(o_move));
        end

    // no row accepted during a search
    busy_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_busy |-> !o_row_ack)
        else begin
            errors = errors + 1;
            $display("row acknowledged while a search was running");
        end

    task automatic tick();
        @(posedge i_clk);
        #1;
    endtask

    task automatic send_row(input row_t row);
        i_row     = row;
        i_row_req = 1'b1;
        tick();
        while (!o_row_ack) tick();
        i_row_req = 1'b0;
        tick();
        while (o_row_ack) tick();
    endtask

    task automatic load_rows(input int first);
        for (int r = first; r < `VCF_N; r++) begin
            send_row(puz[r * `VCF_N +: `VCF_N]);
        end
    endtask

    task automatic wait_verdict();
        while (!o_done) tick();
        // one more edge so the verdict is sampled against this expectation
        tick();
    endtask

    task automatic clear_board(input bit fill);
        puz = '0;
        if (fill) begin
            // defender filler on rows 0 to 2
            for (int i = 0; i < 3 * `VCF_N; i++) begin
                if (($random(seed) & 3) == 0) begin
                    puz[i] = CELL_DEF;
                end
            end
        end
    endtask

    task automatic put_stone(input int r, input int c, input cell_t v);
        puz[r * `VCF_N + c] = v;
    endtask

    task automatic put_run(input int r, input int c0, input int n, input cell_t v);
        for (int c = c0; c < c0 + n; c++) begin
            put_stone(r, c, v);
        end
    endtask

    task automatic set_expected(input logic win, input int r, input int c);
        exp_win    = win;
        exp_move.x = coord_t'(c);
        exp_move.y = coord_t'(r);
    endtask

    // closed three on row 10 and a pair on column 7 meeting at (10,7)
    task automatic setup_chain(input bit blocked);
        put_run(10, 4, 3, CELL_ATK);
        put_stone(10, 3, CELL_DEF);
        put_stone(8, 7, CELL_ATK);
        put_stone(9, 7, CELL_ATK);
        if (blocked) begin
            put_stone(7, 7, CELL_DEF);
        end
    endtask

    // two closed fours needed before the open four on column 7
    task automatic setup_deep();
        put_run(9, 8, 3, CELL_ATK);
        put_stone(9, 11, CELL_DEF);
        put_run(10, 3, 3, CELL_ATK);
        put_stone(10, 2, CELL_DEF);
        put_stone(10, 8, CELL_DEF);
        put_stone(11, 7, CELL_ATK);
    endtask

    initial begin
        seed      = 80;
        errors    = 0;
        cycles    = 0;
        i_clk     = 1'b0;
        i_rst_n   = 1'b1;
        i_row_req = 1'b0;
        i_row     = '0;
        exp_win   = 1'b0;
        exp_move  = '0;
        puz       = '0;
        #10;
        i_rst_n = 1'b0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        tick();

        // empty board
        clear_board(1'b0);
        set_expected(1'b0, 0, 0);
        load_rows(0);
        wait_verdict();

        // four against the left edge
        clear_board(1'b1);
        put_run(8, 0, 4, CELL_ATK);
        set_expected(1'b1, 8, 4);
        load_rows(0);
        wait_verdict();

        // open four where the lower end wins the tie
        clear_board(1'b1);
        put_run(9, 5, 4, CELL_ATK);
        set_expected(1'b1, 9, 4);
        load_rows(0);
        wait_verdict();

        // four at (10,7) forces a block before an open four on column 7
        clear_board(1'b1);
        setup_chain(1'b0);
        set_expected(1'b1, 10, 7);
        load_rows(0);
        wait_verdict();

        // same with column 7 capped
        clear_board(1'b1);
        setup_chain(1'b1);
        set_expected(1'b0, 0, 0);
        load_rows(0);

        // first row of the next board offered during the search
        clear_board(1'b1);
        setup_deep();
        i_row     = puz[0 +: `VCF_N];
        i_row_req = 1'b1;
        wait_verdict();
        while (!o_row_ack) tick();
        i_row_req = 1'b0;
        tick();
        while (o_row_ack) tick();

        // chain is one four too long for the depth
        set_expected(1'b0, 0, 0);
        load_rows(1);
        wait_verdict();

        $display("checks finished, verdict errors %0d, protocol errors %0d",
                 errors, dut0.u_checker.fail_cnt);
        if (errors == 0 && dut0.u_checker.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
